//--- hw/dbg_settings.svh
// sizes and character codes for the register-dump debugger, included by rtl and testbench.
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// line buffer geometry.
`define DBG_BUF_DEPTH 256
`define DBG_BUF_AW 8

// cpu register geometry.
`define DBG_ADDR_W 20
`define DBG_ADDR_NIBBLES 5
`define DBG_WORD_NIBBLES 16
`define DBG_ST_W 16
`define DBG_HST_W 4

// control characters that open every dump line.
`define DBG_CHR_LF 8'd10
`define DBG_CHR_CR 8'd13

`endif

//--- hw/dbg_regs_pkg.sv
// cpu-side types of the debugger, imported by the rtl and the testbench register model.
`default_nettype none

`include "dbg_settings.svh"

package dbg_regs_pkg;

    // register selected on the debug read port.
    typedef enum logic [4:0] {
        REG_A    = 5'd0,
        REG_B    = 5'd1,
        REG_C    = 5'd2,
        REG_D    = 5'd3,
        REG_D0   = 5'd4,
        REG_D1   = 5'd5,
        REG_NONE = 5'd31
    } dbg_reg_sel_t;

    typedef logic [3:0] dbg_nibble_t;
    typedef logic [`DBG_ADDR_W-1:0] dbg_addr_t;

endpackage

`default_nettype wire

//--- hw/dbg_text_pkg.sv
// text-side types of the debugger, imported by the rtl and the testbench layout builder.
`default_nettype none

`include "dbg_settings.svh"

package dbg_text_pkg;

    typedef logic [7:0] dbg_char_t;
    typedef logic [`DBG_BUF_AW-1:0] dbg_buf_addr_t;

    // sequencer fields, in the order they appear in the dump.
    typedef enum logic [3:0] {
        FLD_IDLE,
        FLD_PC,
        FLD_FLAGS,
        FLD_PHST,
        FLD_ST,
        FLD_REG,
        FLD_D0,
        FLD_D1,
        FLD_END,
        FLD_DRAIN
    } dbg_field_t;

    // uppercase ascii hex digit.
    function automatic dbg_char_t hex_digit(input dbg_regs_pkg::dbg_nibble_t n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h37 + {4'h0, n};
    endfunction

endpackage

`default_nettype wire

//--- hw/dbg_dump_gen.sv
// field sequencer that composes the register snapshot into the line buffer and drains it.
`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_dump_gen
    import dbg_regs_pkg::*, dbg_text_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_clk_en,
    input  wire                  i_instr_decoded,
    input  wire                  i_alu_busy,
    input  wire dbg_addr_t       i_current_pc,
    input  wire                  i_reg_carry,
    input  wire                  i_reg_alu_mode,
    input  wire dbg_nibble_t     i_reg_p,
    input  wire [`DBG_HST_W-1:0] i_reg_hst,
    input  wire [`DBG_ST_W-1:0]  i_reg_st,
    input  wire dbg_nibble_t     i_dbg_reg_nibble,
    output dbg_reg_sel_t         o_dbg_register,
    output dbg_nibble_t          o_dbg_reg_ptr,
    output logic                 o_debug_cycle,
    output logic                 o_wr_en,
    output dbg_buf_addr_t        o_wr_addr,
    output dbg_char_t            o_wr_char,
    output dbg_buf_addr_t        o_rd_addr,
    input  wire dbg_char_t       i_rd_char,
    output logic                 o_dump_req,
    output dbg_char_t            o_dump_char,
    input  wire                  i_dump_grant
);

    // widest field is a register line of 21 characters.
    localparam int TXT_W = 8 * 21;

    dbg_field_t    field;
    logic [4:0]    pos;
    logic [1:0]    reg_idx;
    dbg_buf_addr_t wr_addr;
    dbg_buf_addr_t rd_addr;
    logic          rd_ready;

    logic [TXT_W-1:0]               line_txt;
    logic [4:0]                     txt_len;
    logic [4:0]                     dig_len;
    logic [4:0]                     fld_len;
    dbg_reg_sel_t                   port_sel;
    dbg_reg_sel_t                   word_sel;
    logic                           composing;
    logic                           from_port;
    logic [8*`DBG_ST_W-1:0]         st_txt;
    logic [8*`DBG_ST_W-1:0]         hst_txt;
    logic [8*`DBG_ADDR_NIBBLES-1:0] pc_txt;
    dbg_char_t                      comp_char;

    // one "0" or "1" per bit, msb leftmost.
    function automatic logic [8*`DBG_ST_W-1:0] bit_text(input logic [`DBG_ST_W-1:0] v);
        logic [8*`DBG_ST_W-1:0] r;
        for (int i = 0; i < `DBG_ST_W; i++) begin
            r[8*i +: 8] = v[i] ? "1" : "0";
        end
        return r;
    endfunction

    function automatic logic [8*`DBG_ADDR_NIBBLES-1:0] addr_text(input dbg_addr_t a);
        logic [8*`DBG_ADDR_NIBBLES-1:0] r;
        for (int i = 0; i < `DBG_ADDR_NIBBLES; i++) begin
            r[8*i +: 8] = hex_digit(a[4*i +: 4]);
        end
        return r;
    endfunction

    // ################################################
    // character of the current field position
    // ################################################

    always_comb begin
        st_txt  = bit_text(i_reg_st);
        hst_txt = bit_text({{(`DBG_ST_W-`DBG_HST_W){1'b0}}, i_reg_hst});
        pc_txt  = addr_text(i_current_pc);
        case (reg_idx)
            2'd0:    word_sel = REG_A;
            2'd1:    word_sel = REG_B;
            2'd2:    word_sel = REG_C;
            default: word_sel = REG_D;
        endcase
        // text is right aligned in line_txt, port digits follow it.
        line_txt = '0;
        txt_len  = 5'd1;
        dig_len  = 5'd0;
        port_sel = REG_NONE;
        case (field)
            FLD_PC: begin
                line_txt = TXT_W'({`DBG_CHR_LF, `DBG_CHR_CR, "PC: ", pc_txt});
                txt_len  = 5'd6 + 5'(`DBG_ADDR_NIBBLES);
            end
            FLD_FLAGS: begin
                line_txt = TXT_W'({" Carry: ", i_reg_carry ? "1" : "0", " h: ",
                                   i_reg_alu_mode ? "DEC" : "HEX"});
                txt_len  = 5'd16;
            end
            FLD_PHST: begin
                line_txt = TXT_W'({`DBG_CHR_LF, `DBG_CHR_CR, "P: ", hex_digit(i_reg_p),
                                   " HST: ", hst_txt[8*`DBG_HST_W-1:0]});
                txt_len  = 5'd16;
            end
            FLD_ST: begin
                line_txt = TXT_W'({" ST: ", st_txt});
                txt_len  = 5'd5 + 5'(`DBG_ST_W);
            end
            FLD_REG: begin
                line_txt = TXT_W'({`DBG_CHR_LF, `DBG_CHR_CR, 8'h41 + {6'd0, reg_idx}, ": "});
                txt_len  = 5'd5;
                dig_len  = 5'(`DBG_WORD_NIBBLES);
                port_sel = word_sel;
            end
            FLD_D0: begin
                line_txt = TXT_W'({`DBG_CHR_LF, `DBG_CHR_CR, "D0: "});
                txt_len  = 5'd6;
                dig_len  = 5'(`DBG_ADDR_NIBBLES);
                port_sel = REG_D0;
            end
            FLD_D1: begin
                line_txt = TXT_W'(" D1: ");
                txt_len  = 5'd5;
                dig_len  = 5'(`DBG_ADDR_NIBBLES);
                port_sel = REG_D1;
            end
            FLD_END: begin
                line_txt = TXT_W'({`DBG_CHR_LF, `DBG_CHR_CR});
                txt_len  = 5'd2;
            end
            default: begin
            end
        endcase
        fld_len   = txt_len + dig_len;
        composing = (field != FLD_IDLE) && (field != FLD_DRAIN);
        from_port = pos >= txt_len;
        if (from_port) begin
            comp_char = hex_digit(i_dbg_reg_nibble);
        end else begin
            comp_char = line_txt[8*(txt_len - 5'd1 - pos) +: 8];
        end
    end

    // digits come out msb first.
    assign o_dbg_register = (composing && from_port) ? port_sel : REG_NONE;
    assign o_dbg_reg_ptr  = 4'(fld_len - 5'd1 - pos);

    assign o_wr_en     = composing;
    assign o_wr_addr   = wr_addr;
    assign o_wr_char   = comp_char;
    assign o_rd_addr   = rd_addr;
    assign o_dump_req  = (field == FLD_DRAIN) && rd_ready;
    assign o_dump_char = i_rd_char;

    // ################################################
    // sequencer
    // ################################################

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            field         <= FLD_IDLE;
            pos           <= 5'd0;
            rd_ready      <= 1'b0;
            o_debug_cycle <= 1'b0;
        end else begin
            case (field)
                FLD_IDLE: begin
                    if (i_clk_en && i_instr_decoded && !i_alu_busy) begin
                        field         <= FLD_PC;
                        pos           <= 5'd0;
                        reg_idx       <= 2'd0;
                        wr_addr       <= '0;
                        rd_addr       <= '0;
                        rd_ready      <= 1'b1;
                        o_debug_cycle <= 1'b1;
                    end
                end
                FLD_DRAIN: begin
                    // read data lags the address by one cycle.
                    if (i_dump_grant) begin
                        rd_ready <= 1'b0;
                        rd_addr  <= rd_addr + 1'b1;
                        if ((rd_addr + 1'b1) == wr_addr) begin
                            field         <= FLD_IDLE;
                            o_debug_cycle <= 1'b0;
                        end
                    end else begin
                        rd_ready <= 1'b1;
                    end
                end
                default: begin
                    wr_addr <= wr_addr + 1'b1;
                    if (pos == fld_len - 5'd1) begin
                        pos <= 5'd0;
                        if (field == FLD_REG && reg_idx != 2'd3) begin
                            reg_idx <= reg_idx + 2'd1;
                        end else begin
                            field <= dbg_field_t'(field + 4'd1);
                        end
                    end else begin
                        pos <= pos + 5'd1;
                    end
                end
            endcase
        end
    end

    // write index never wraps past the end of the buffer.
    a_no_wrap: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wr_en |=> (o_wr_addr != '0));

endmodule

`default_nettype wire

//--- hw/dbg_line_buffer.sv
// character store holding one composed snapshot, written by the sequencer and read on drain.
`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_line_buffer
    import dbg_text_pkg::*;
(
    input  wire                i_clk,
    input  wire                i_wr_en,
    input  wire dbg_buf_addr_t i_wr_addr,
    input  wire dbg_char_t     i_wr_char,
    input  wire dbg_buf_addr_t i_rd_addr,
    output dbg_char_t          o_rd_char
);

    // block ram style, one write and one registered read port.
    dbg_char_t mem [0:`DBG_BUF_DEPTH-1];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_char;
        end
    end

    // data valid the cycle after the address.
    always_ff @(posedge i_clk) begin
        o_rd_char <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/dbg_bus_trace.sv
// turns bus read and bus busy pulses into one pending trace character for the arbiter.
`timescale 1ns/10ps
`default_nettype none

module dbg_bus_trace
    import dbg_regs_pkg::*, dbg_text_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_bus_read_valid,
    input  wire dbg_nibble_t i_bus_nibble_in,
    input  wire              i_bus_busy_valid,
    output logic             o_trace_req,
    output dbg_char_t        o_trace_char,
    input  wire              i_trace_grant
);

    // a new event overrides both a pending char and a grant.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_trace_req <= 1'b0;
        end else if (i_bus_busy_valid || i_bus_read_valid) begin
            o_trace_req <= 1'b1;
        end else if (i_trace_grant) begin
            o_trace_req <= 1'b0;
        end
    end

    // busy dot wins over a read nibble.
    always_ff @(posedge i_clk) begin
        if (i_bus_busy_valid) begin
            o_trace_char <= ".";
        end else if (i_bus_read_valid) begin
            o_trace_char <= hex_digit(i_bus_nibble_in);
        end
    end

endmodule

`default_nettype wire

//--- hw/dbg_serial_arbiter.sv
// shares the serial character port between bus trace and dump drain, trace first.
`timescale 1ns/10ps
`default_nettype none

module dbg_serial_arbiter
    import dbg_text_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_reset,
    input  wire            i_trace_req,
    input  wire dbg_char_t i_trace_char,
    output logic           o_trace_grant,
    input  wire            i_dump_req,
    input  wire dbg_char_t i_dump_char,
    output logic           o_dump_grant,
    input  wire            i_serial_busy,
    output dbg_char_t      o_char_to_send,
    output logic           o_char_valid,
    output logic           o_char_send
);

    logic can_send;

    // one slot per free cycle, never back to back.
    assign can_send      = !i_serial_busy && !o_char_valid;
    assign o_trace_grant = can_send && i_trace_req;
    assign o_dump_grant  = can_send && i_dump_req && !i_trace_req;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_char_valid <= 1'b0;
            o_char_send  <= 1'b0;
        end else begin
            o_char_valid <= o_trace_grant || o_dump_grant;
            if (o_trace_grant || o_dump_grant) begin
                o_char_send <= ~o_char_send;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_trace_grant) begin
            o_char_to_send <= i_trace_char;
        end else if (o_dump_grant) begin
            o_char_to_send <= i_dump_char;
        end
    end

    // a waiting dump character stays offered, unchanged, until its grant.
    a_dump_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_dump_req && !o_dump_grant) |=> (i_dump_req && $stable(i_dump_char)));

    // a pending trace character is never dropped before its grant.
    a_trace_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_trace_req && !o_trace_grant) |=> i_trace_req);

endmodule

`default_nettype wire

//--- hw/dbg_top.sv
// top of the register-dump debugger, connecting sequencer, line buffer, bus trace and arbiter.
`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_top
    import dbg_regs_pkg::*, dbg_text_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_clk_en,
    input  wire                  i_instr_decoded,
    input  wire                  i_alu_busy,
    input  wire dbg_addr_t       i_current_pc,
    input  wire                  i_reg_carry,
    input  wire                  i_reg_alu_mode,
    input  wire dbg_nibble_t     i_reg_p,
    input  wire [`DBG_HST_W-1:0] i_reg_hst,
    input  wire [`DBG_ST_W-1:0]  i_reg_st,
    output dbg_reg_sel_t         o_dbg_register,
    output dbg_nibble_t          o_dbg_reg_ptr,
    input  wire dbg_nibble_t     i_dbg_reg_nibble,
    output logic                 o_debug_cycle,
    input  wire                  i_bus_read_valid,
    input  wire dbg_nibble_t     i_bus_nibble_in,
    input  wire                  i_bus_busy_valid,
    input  wire                  i_serial_busy,
    output dbg_char_t            o_char_to_send,
    output logic                 o_char_valid,
    output logic                 o_char_send
);

    // sequencer to buffer.
    logic          wr_en;
    dbg_buf_addr_t wr_addr;
    dbg_char_t     wr_char;
    dbg_buf_addr_t rd_addr;
    dbg_char_t     rd_char;

    // requesters to arbiter.
    logic      dump_req;
    dbg_char_t dump_char;
    logic      dump_grant;
    logic      trace_req;
    dbg_char_t trace_char;
    logic      trace_grant;

    dbg_dump_gen dump_gen_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clk_en         (i_clk_en),
        .i_instr_decoded  (i_instr_decoded),
        .i_alu_busy       (i_alu_busy),
        .i_current_pc     (i_current_pc),
        .i_reg_carry      (i_reg_carry),
        .i_reg_alu_mode   (i_reg_alu_mode),
        .i_reg_p          (i_reg_p),
        .i_reg_hst        (i_reg_hst),
        .i_reg_st         (i_reg_st),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_debug_cycle    (o_debug_cycle),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_char        (wr_char),
        .o_rd_addr        (rd_addr),
        .i_rd_char        (rd_char),
        .o_dump_req       (dump_req),
        .o_dump_char      (dump_char),
        .i_dump_grant     (dump_grant)
    );

    dbg_line_buffer line_buffer_i (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_char (wr_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char)
    );

    dbg_bus_trace bus_trace_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_bus_read_valid (i_bus_read_valid),
        .i_bus_nibble_in  (i_bus_nibble_in),
        .i_bus_busy_valid (i_bus_busy_valid),
        .o_trace_req      (trace_req),
        .o_trace_char     (trace_char),
        .i_trace_grant    (trace_grant)
    );

    dbg_serial_arbiter serial_arbiter_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_trace_req    (trace_req),
        .i_trace_char   (trace_char),
        .o_trace_grant  (trace_grant),
        .i_dump_req     (dump_req),
        .i_dump_char    (dump_char),
        .o_dump_grant   (dump_grant),
        .i_serial_busy  (i_serial_busy),
        .o_char_to_send (o_char_to_send),
        .o_char_valid   (o_char_valid),
        .o_char_send    (o_char_send)
    );

endmodule

`default_nettype wire

//--- test/tb_dbg_cases.svh
// stimulus table for the debugger testbench, included inside tb_dbg_top and loaded at start.
`ifndef TB_DBG_CASES_SVH
`define TB_DBG_CASES_SVH

// one register snapshot, whether serial busy is random, busy dots traced during the drain.
typedef struct packed {
    dbg_addr_t             pc;
    logic                  carry;
    logic                  mode;
    dbg_nibble_t           p;
    logic [`DBG_HST_W-1:0] hst;
    logic [`DBG_ST_W-1:0]  st;
    logic [63:0]           a;
    logic [63:0]           b;
    logic [63:0]           c;
    logic [63:0]           d;
    dbg_addr_t             d0;
    dbg_addr_t             d1;
    logic                  rand_busy;
    int                    n_dots;
} case_row_t;

localparam int N_CASES = 4;

case_row_t cases [N_CASES];

// dots only go in rows with a free serial port, so no dot is overwritten before its grant.
task automatic load_cases();
    cases[0] = '{20'h00000, 1'b0, 1'b0, 4'h0, 4'h0, 16'h0000,
                 64'h0, 64'h0, 64'h0, 64'h0,
                 20'h00000, 20'h00000, 1'b0, 0};
    cases[1] = '{20'h3A5C1, 1'b1, 1'b0, 4'h9, 4'b1010, 16'hC35A,
                 64'h0123456789ABCDEF, 64'hFEDCBA9876543210,
                 64'h00000000DEADBEEF, 64'h8000000000000001,
                 20'h12345, 20'hABCDE, 1'b1, 0};
    cases[2] = '{20'hFFFFF, 1'b0, 1'b1, 4'hF, 4'b0110, 16'h8001,
                 64'h5555AAAA5555AAAA, 64'h0F0F0F0F0F0F0F0F,
                 64'h1122334455667788, 64'h99AABBCCDDEEFF00,
                 20'h0000F, 20'hF0000, 1'b0, 3};
    cases[3] = '{20'hFFFFF, 1'b1, 1'b1, 4'hF, 4'hF, 16'hFFFF,
                 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF,
                 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF,
                 20'hFFFFF, 20'hFFFFF, 1'b1, 0};
endtask

`endif

//--- test/tb_dbg_top.sv
// testbench for the register-dump debugger, built from compile.f and run by run_sim.sh.
`timescale 1ns/10ps
`default_nettype none

`include "dbg_settings.svh"

module tb_dbg_top
    import dbg_regs_pkg::*, dbg_text_pkg::*;
;

    localparam int DUMP_LEN     = 171;
    localparam int CHAR_TIMEOUT = 2000;
    localparam int WAIT_TIMEOUT = 500;

    `include "tb_dbg_cases.svh"

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  clk_en = 1'b0;
    logic                  instr_decoded = 1'b0;
    logic                  alu_busy = 1'b0;
    dbg_addr_t             current_pc = '0;
    logic                  reg_carry = 1'b0;
    logic                  reg_alu_mode = 1'b0;
    dbg_nibble_t           reg_p = '0;
    logic [`DBG_HST_W-1:0] reg_hst = '0;
    logic [`DBG_ST_W-1:0]  reg_st = '0;
    dbg_nibble_t           reg_nibble;
    logic                  bus_read_valid = 1'b0;
    dbg_nibble_t           bus_nibble = '0;
    logic                  bus_busy_valid = 1'b0;
    logic                  serial_busy = 1'b0;
    dbg_reg_sel_t          dbg_register;
    dbg_nibble_t           dbg_reg_ptr;
    logic                  debug_cycle;
    dbg_char_t             char_to_send;
    logic                  char_valid;
    logic                  char_send;

    case_row_t   cur = '0;
    dbg_char_t   exp_text [$];
    logic        busy_random = 1'b0;
    logic        busy_prev = 1'b0;
    logic        send_prev = 1'b0;
    int          char_count = 0;
    int          dots_seen = 0;
    int          seed = 32'hcc08f26d;
    int          rnd;

    dbg_top dut_i (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_clk_en         (clk_en),
        .i_instr_decoded  (instr_decoded),
        .i_alu_busy       (alu_busy),
        .i_current_pc     (current_pc),
        .i_reg_carry      (reg_carry),
        .i_reg_alu_mode   (reg_alu_mode),
        .i_reg_p          (reg_p),
        .i_reg_hst        (reg_hst),
        .i_reg_st         (reg_st),
        .o_dbg_register   (dbg_register),
        .o_dbg_reg_ptr    (dbg_reg_ptr),
        .i_dbg_reg_nibble (reg_nibble),
        .o_debug_cycle    (debug_cycle),
        .i_bus_read_valid (bus_read_valid),
        .i_bus_nibble_in  (bus_nibble),
        .i_bus_busy_valid (bus_busy_valid),
        .i_serial_busy    (serial_busy),
        .o_char_to_send   (char_to_send),
        .o_char_valid     (char_valid),
        .o_char_send      (char_send)
    );

    always #20 clk = ~clk;

    // cpu register file, answered in the same cycle.
    always_comb begin
        case (dbg_register)
            REG_A:   reg_nibble = cur.a[4*dbg_reg_ptr +: 4];
            REG_B:   reg_nibble = cur.b[4*dbg_reg_ptr +: 4];
            REG_C:   reg_nibble = cur.c[4*dbg_reg_ptr +: 4];
            REG_D:   reg_nibble = cur.d[4*dbg_reg_ptr +: 4];
            REG_D0:  reg_nibble = cur.d0[4*dbg_reg_ptr +: 4];
            REG_D1:  reg_nibble = cur.d1[4*dbg_reg_ptr +: 4];
            default: reg_nibble = 4'h0;
        endcase
    end

    always @(posedge clk) begin
        #2;
        if (busy_random) begin
            rnd = $random(seed);
            serial_busy = rnd[0];
        end else begin
            serial_busy = 1'b0;
        end
    end

    // ################################################
    // reporting and compare tasks
    // ################################################

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // next character at a valid pulse, trace dots skipped when asked.
    task automatic check_char(input dbg_char_t exp, input bit skip_dots, input string what);
        int waited;
        bit done;
        waited = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            waited++;
            if (char_valid) begin
                if (skip_dots && char_to_send == ".") begin
                    dots_seen++;
                end else if (char_to_send != exp) begin
                    abort_run($sformatf("FAIL at %0t: %s is %h, expected %h",
                                        $time, what, char_to_send, exp));
                end else begin
                    done = 1'b1;
                end
            end else if (waited > CHAR_TIMEOUT) begin
                abort_run($sformatf("no character arrived in time for %s", what));
            end
        end
    endtask

    task automatic check_reg_sel(input dbg_reg_sel_t exp, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (dbg_register != exp) begin
            if (waited < WAIT_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end else begin
                abort_run($sformatf("FAIL at %0t: %s is %s, expected %s",
                                    $time, what, dbg_register.name(), exp.name()));
            end
        end
    endtask

    task automatic wait_debug_cycle(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (debug_cycle !== level) begin
            if (waited < WAIT_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end else begin
                abort_run($sformatf("the debug cycle never went to %b", level));
            end
        end
    endtask

    // every character must follow a free cycle and flip the send strobe.
    always @(negedge clk) begin
        if (!reset && char_valid) begin
            if (busy_prev) begin
                abort_run("a character went out while the serial port was busy");
            end
            check_bit(char_send, !send_prev, "send strobe");
            send_prev = char_send;
            char_count++;
        end
        busy_prev = serial_busy;
    end

    // ################################################
    // expected dump text
    // ################################################

    function automatic dbg_char_t hex_char(input logic [3:0] n);
        string digits;
        digits = "0123456789ABCDEF";
        return dbg_char_t'(digits[n]);
    endfunction

    task automatic add_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_text.push_back(dbg_char_t'(s[i]));
        end
    endtask

    task automatic add_newline();
        exp_text.push_back(`DBG_CHR_LF);
        exp_text.push_back(`DBG_CHR_CR);
    endtask

    // msb nibble first.
    task automatic add_hex(input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_text.push_back(hex_char(v[4*i +: 4]));
        end
    endtask

    task automatic add_bits(input logic [15:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_text.push_back(v[i] ? 8'h31 : 8'h30);
        end
    endtask

    task automatic build_expected(input case_row_t row);
        string       letters;
        logic [63:0] words [4];
        letters = "ABCD";
        words = '{row.a, row.b, row.c, row.d};
        exp_text.delete();
        add_newline();
        add_text("PC: ");
        add_hex(64'(row.pc), 5);
        add_text(row.carry ? " Carry: 1 h: " : " Carry: 0 h: ");
        add_text(row.mode ? "DEC" : "HEX");
        add_newline();
        add_text("P: ");
        add_hex(64'(row.p), 1);
        add_text(" HST: ");
        add_bits(16'(row.hst), 4);
        add_text(" ST: ");
        add_bits(row.st, 16);
        for (int k = 0; k < 4; k++) begin
            add_newline();
            exp_text.push_back(dbg_char_t'(letters[k]));
            add_text(": ");
            add_hex(words[k], 16);
        end
        add_newline();
        add_text("D0: ");
        add_hex(64'(row.d0), 5);
        add_text(" D1: ");
        add_hex(64'(row.d1), 5);
        add_newline();
    endtask

    // ################################################
    // sequences
    // ################################################

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic trace_alone();
        dbg_nibble_t nibs [3];
        nibs = '{4'hA, 4'h0, 4'h7};
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            bus_nibble = nibs[i];
            bus_read_valid = 1'b1;
            next_cycle();
            bus_read_valid = 1'b0;
            check_char(hex_char(nibs[i]), 1'b0, "traced bus nibble");
        end
        next_cycle();
        bus_busy_valid = 1'b1;
        next_cycle();
        bus_busy_valid = 1'b0;
        check_char(".", 1'b0, "traced busy dot");
    endtask

    // retrigger and busy dots while the buffer drains.
    task automatic disturb_drain(input int n_dots);
        wait_debug_cycle(1'b1);
        check_reg_sel(REG_A, "register port during compose");
        repeat (130) next_cycle();
        instr_decoded = 1'b1;
        repeat (4) next_cycle();
        instr_decoded = 1'b0;
        for (int i = 0; i < n_dots; i++) begin
            bus_busy_valid = 1'b1;
            next_cycle();
            bus_busy_valid = 1'b0;
            repeat (12) next_cycle();
        end
    endtask

    task automatic verify_dump(input int r);
        build_expected(cur);
        foreach (exp_text[i]) begin
            check_char(exp_text[i], 1'b1, $sformatf("dump %0d character %0d", r, i));
        end
        check_bit(debug_cycle, 1'b0, "debug cycle after the last character");
    endtask

    task automatic run_case(input int r);
        cur = cases[r];
        next_cycle();
        current_pc = cur.pc;
        reg_carry = cur.carry;
        reg_alu_mode = cur.mode;
        reg_p = cur.p;
        reg_hst = cur.hst;
        reg_st = cur.st;
        busy_random = cur.rand_busy;
        char_count = 0;
        dots_seen = 0;
        clk_en = 1'b0;
        instr_decoded = 1'b1;
        next_cycle();
        check_bit(debug_cycle, 1'b0, "debug cycle without clock enable");
        clk_en = 1'b1;
        alu_busy = 1'b1;
        next_cycle();
        check_bit(debug_cycle, 1'b0, "debug cycle while the alu is busy");
        alu_busy = 1'b0;
        next_cycle();
        instr_decoded = 1'b0;
        fork
            disturb_drain(cur.n_dots);
            verify_dump(r);
        join
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_bit(debug_cycle, 1'b0, "debug cycle after the dump");
        end
        check_count(char_count, DUMP_LEN + cur.n_dots, "characters sent for the dump");
        check_count(dots_seen, cur.n_dots, "busy dots inside the dump");
    endtask

    initial begin
        load_cases();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        check_reg_sel(REG_NONE, "register select after reset");
        check_bit(debug_cycle, 1'b0, "debug cycle after reset");
        check_bit(char_valid, 1'b0, "char valid after reset");
        check_bit(char_send, 1'b0, "send strobe after reset");
        trace_alone();
        for (int r = 0; r < N_CASES; r++) begin
            run_case(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
+incdir+test
hw/dbg_regs_pkg.sv
hw/dbg_text_pkg.sv
hw/dbg_dump_gen.sv
hw/dbg_line_buffer.sv
hw/dbg_bus_trace.sv
hw/dbg_serial_arbiter.sv
hw/dbg_top.sv
test/tb_dbg_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debugger testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dbg_top \
        -f compile.f --Mdir obj_dir -o tb_dbg_top; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_dbg_top; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0
